/* source/cnn_data_pkg.sv */
`default_nettype none

package cnn_data_pkg;

  // One activation word from a convolution branch
  typedef logic [31:0] pixel_t;

  // Strobe plus word on every stream edge of the stage
  typedef struct packed {
    logic   valid;
    pixel_t data;
  } pixel_beat_t;

  // Registered occupancy flags of a channel FIFO
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_status_t;

  // Branch currently being drained
  typedef enum logic [2:0] {
    BR1,
    BR2,
    BR3,
    BR4,
    BR5
  } branch_id_t;

  // Drain controller states
  typedef enum logic {
    CONCAT_IDLE,
    CONCAT_DRAIN
  } concat_state_t;

endpackage

`default_nettype wire

/* source/concat_cfg_pkg.sv */
`default_nettype none

package concat_cfg_pkg;

  // Branches joined into one output stream
  localparam int BRANCH_NUM = 5;

  // Pixels in one branch map, kept small for simulation
  localparam int CHANNEL_NUM_PIXEL = 16;

  // FIFO address and word count width
  localparam int POINTER_WIDTH = $clog2(CHANNEL_NUM_PIXEL);

  // Drained-word counter, one spare bit over the pointer
  localparam int COUNT_WIDTH = POINTER_WIDTH + 1;

endpackage

`default_nettype wire

/* source/channel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_fifo #(
  parameter int DEPTH = concat_cfg_pkg::CHANNEL_NUM_PIXEL
) (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire cnn_data_pkg::pixel_beat_t wr_beat,
  input  wire logic                      read,
  output cnn_data_pkg::pixel_beat_t      rd_beat,
  output cnn_data_pkg::fifo_status_t     status
);

  import cnn_data_pkg::*;

  // Address width and occupancy width, the count must reach DEPTH
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  pixel_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             do_write;
  logic             do_read;

  // Circular increment, also right for non power of two depths
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Occupancy

  assign do_write = wr_beat.valid;
  // Reads on an empty buffer are dropped
  assign do_read  = read && !status.empty;

  always_comb begin
    case ({do_write, do_read})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      // Idle or simultaneous read and write
      default: count_next = count;
    endcase
  end

  ////////////////////////////////////////
  // Storage

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_beat.data;
    end
  end

  ////////////////////////////////////////
  // Pointers, flags and read port

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      status.empty  <= 1'b1;
      status.full   <= 1'b0;
      rd_beat.valid <= 1'b0;
    end else begin
      if (do_write) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count         <= count_next;
      // Flags follow the count after this edge
      status.empty  <= (count_next == '0);
      status.full   <= (count_next == CNT_W'(DEPTH));
      // Head word shows up one cycle after the read
      rd_beat.valid <= do_read;
    end
    if (do_read) begin
      rd_beat.data <= mem[rd_ptr];
    end
  end

  // Branch source never overruns its map buffer
  a_no_write_full: assert property (
    @(posedge clk) disable iff (reset) wr_beat.valid |-> !status.full
  ) else $error("channel_fifo write while full");

  // Drain controller only reads a branch that holds data
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (reset) read |-> !status.empty
  ) else $error("channel_fifo read while empty");

endmodule

`default_nettype wire

/* source/concat_drain_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module concat_drain_ctrl (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire cnn_data_pkg::fifo_status_t     status  [concat_cfg_pkg::BRANCH_NUM],
  input  wire cnn_data_pkg::pixel_beat_t      rd_beat [concat_cfg_pkg::BRANCH_NUM],
  output logic [concat_cfg_pkg::BRANCH_NUM-1:0] read_en,
  output cnn_data_pkg::pixel_beat_t           out
);

  import cnn_data_pkg::*;
  import concat_cfg_pkg::*;

  concat_state_t          state;
  branch_id_t             branch;
  logic [COUNT_WIDTH-1:0] count;
  logic                   issue;
  logic                   map_done;
  logic [BRANCH_NUM-1:0]  beat_valid;
  pixel_beat_t            sel_beat;

  ////////////////////////////////////////
  // Read request

  // Only the current branch, and only when it has a word
  always_comb begin
    read_en = '0;
    if (state == CONCAT_DRAIN && !status[branch].empty) begin
      read_en[branch] = 1'b1;
    end
  end

  assign issue    = |read_en;
  // Last read of the current map
  assign map_done = issue && (count == COUNT_WIDTH'(CHANNEL_NUM_PIXEL - 1));

  ////////////////////////////////////////
  // Branch sequencing

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= CONCAT_IDLE;
      branch <= BR1;
      count  <= '0;
    end else begin
      case (state)
        CONCAT_IDLE: begin
          // Frame starts once branch 1 holds its whole map
          if (status[0].full) begin
            state  <= CONCAT_DRAIN;
            branch <= BR1;
            count  <= '0;
          end
        end
        CONCAT_DRAIN: begin
          if (map_done) begin
            count <= '0;
            if (branch == BR5) begin
              // Whole frame issued
              state  <= CONCAT_IDLE;
              branch <= BR1;
            end else begin
              branch <= branch_id_t'(branch + 3'd1);
            end
          end else if (issue) begin
            count <= count + 1'b1;
          end
          // No word from a late branch leaves a gap
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Output selection

  always_comb begin
    sel_beat = '0;
    for (int k = 0; k < BRANCH_NUM; k++) begin
      beat_valid[k] = rd_beat[k].valid;
      if (rd_beat[k].valid) begin
        sel_beat = rd_beat[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= sel_beat.valid;
    end
    if (sel_beat.valid) begin
      out.data <= sel_beat.data;
    end
  end

  ////////////////////////////////////////
  // Checks

  a_read_onehot: assert property (
    @(posedge clk) disable iff (reset) $onehot0(read_en)
  ) else $error("concat_drain_ctrl more than one branch read");

  // Sequencing keeps the FIFO read ports from overlapping
  a_one_beat: assert property (
    @(posedge clk) disable iff (reset) $onehot0(beat_valid)
  ) else $error("concat_drain_ctrl two FIFO words at once");

  // Idle means no reads and a cleared map counter
  a_idle_quiet: assert property (
    @(posedge clk) disable iff (reset)
    (state == CONCAT_IDLE) |-> (read_en == '0 && count == '0)
  ) else $error("concat_drain_ctrl activity while idle");

  // FIFO stage plus output register
  a_read_to_out: assert property (
    @(posedge clk) disable iff (reset) issue |-> ##2 out.valid
  ) else $error("concat_drain_ctrl read without output two cycles later");

endmodule

`default_nettype wire

/* source/cnn_concat_5in.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_concat_5in (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire cnn_data_pkg::pixel_beat_t in_beat [concat_cfg_pkg::BRANCH_NUM],
  output cnn_data_pkg::pixel_beat_t      out
);

  import cnn_data_pkg::*;
  import concat_cfg_pkg::*;

  logic [BRANCH_NUM-1:0] read_en;
  pixel_beat_t           rd_beat [BRANCH_NUM];
  fifo_status_t          status  [BRANCH_NUM];

  ////////////////////////////////////////
  // One map buffer per branch

  channel_fifo #(.DEPTH(CHANNEL_NUM_PIXEL)) fifo_no1 (
    .clk     (clk),
    .reset   (reset),
    .wr_beat (in_beat[0]),
    .read    (read_en[0]),
    .rd_beat (rd_beat[0]),
    .status  (status[0])
  );

  channel_fifo #(.DEPTH(CHANNEL_NUM_PIXEL)) fifo_no2 (
    .clk     (clk),
    .reset   (reset),
    .wr_beat (in_beat[1]),
    .read    (read_en[1]),
    .rd_beat (rd_beat[1]),
    .status  (status[1])
  );

  channel_fifo #(.DEPTH(CHANNEL_NUM_PIXEL)) fifo_no3 (
    .clk     (clk),
    .reset   (reset),
    .wr_beat (in_beat[2]),
    .read    (read_en[2]),
    .rd_beat (rd_beat[2]),
    .status  (status[2])
  );

  channel_fifo #(.DEPTH(CHANNEL_NUM_PIXEL)) fifo_no4 (
    .clk     (clk),
    .reset   (reset),
    .wr_beat (in_beat[3]),
    .read    (read_en[3]),
    .rd_beat (rd_beat[3]),
    .status  (status[3])
  );

  channel_fifo #(.DEPTH(CHANNEL_NUM_PIXEL)) fifo_no5 (
    .clk     (clk),
    .reset   (reset),
    .wr_beat (in_beat[4]),
    .read    (read_en[4]),
    .rd_beat (rd_beat[4]),
    .status  (status[4])
  );

  ////////////////////////////////////////
  // Branch 1 through 5 into a single stream

  concat_drain_ctrl drain0 (
    .clk     (clk),
    .reset   (reset),
    .status  (status),
    .rd_beat (rd_beat),
    .read_en (read_en),
    .out     (out)
  );

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 2;
  localparam int RESET_CYCLES = 4;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Released just after an edge, like the other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

/* test/cnn_concat_5in_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_concat_5in_tb;

  import cnn_data_pkg::*;
  import concat_cfg_pkg::*;

  // Five frames over all tests
  // Back to back test sends two of them
  localparam int TOTAL_WORDS = 5 * BRANCH_NUM * CHANNEL_NUM_PIXEL;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_WORDS + 200;

  logic        clk;
  logic        reset;
  pixel_beat_t in_beat [BRANCH_NUM];
  pixel_beat_t dut_out;

  integer seed;
  // One queue per branch of words not yet seen at the output
  pixel_t model_q [BRANCH_NUM][$];
  int     mon_branch;
  int     mon_word;
  // Pre-drawn stimulus for the late branches
  int     gap_cycles [BRANCH_NUM][CHANNEL_NUM_PIXEL];
  pixel_t late_data  [BRANCH_NUM][CHANNEL_NUM_PIXEL];

  clock_gen clk0 (
    .clk   (clk),
    .reset (reset)
  );

  cnn_concat_5in dut0 (
    .clk     (clk),
    .reset   (reset),
    .in_beat (in_beat),
    .out     (dut_out)
  );

  ////////////////////////////////////////
  // Checking helpers

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compare_pixel(input string name, input pixel_t got, input pixel_t expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("error at %0t ns: %s got %h expected %h",
                                  $time, name, got, expected));
    end
  endtask

  task automatic compare_valid(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("error at %0t ns: %s got %b expected %b",
                                  $time, name, got, expected));
    end
  endtask

  function automatic int pending_words();
    int total;
    total = 0;
    for (int b = 0; b < BRANCH_NUM; b++) begin
      total += model_q[b].size();
    end
    return total;
  endfunction

  ////////////////////////////////////////
  // Output monitor

  // Expected order is whole maps starting with branch 1
  always @(negedge clk) begin
    if (reset === 1'b0 && dut_out.valid === 1'b1) begin
      if (model_q[mon_branch].size() == 0) begin
        stop_with_failure($sformatf("output word at %0t ns while branch %0d had none pending",
                                    $time, mon_branch + 1));
      end else begin
        compare_pixel("out.data", dut_out.data, model_q[mon_branch].pop_front());
        mon_word++;
        if (mon_word == CHANNEL_NUM_PIXEL) begin
          mon_word   = 0;
          mon_branch = (mon_branch + 1) % BRANCH_NUM;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers

  // One random word per cycle on every masked branch
  task automatic write_maps(input logic [BRANCH_NUM-1:0] mask, input int words);
    pixel_t d;
    for (int i = 0; i < words; i++) begin
      @(posedge clk);
      #1;
      for (int b = 0; b < BRANCH_NUM; b++) begin
        if (mask[b]) begin
          d = $random(seed);
          in_beat[b].valid = 1'b1;
          in_beat[b].data  = d;
          model_q[b].push_back(d);
        end
      end
    end
    @(posedge clk);
    #1;
    for (int b = 0; b < BRANCH_NUM; b++) begin
      if (mask[b]) begin
        in_beat[b].valid = 1'b0;
      end
    end
  endtask

  // One late branch with idle cycles between words
  task automatic write_branch_gapped(input int br, input int start_delay);
    repeat (start_delay) @(posedge clk);
    for (int i = 0; i < CHANNEL_NUM_PIXEL; i++) begin
      repeat (gap_cycles[br][i]) @(posedge clk);
      @(posedge clk);
      #1;
      in_beat[br].valid = 1'b1;
      in_beat[br].data  = late_data[br][i];
      model_q[br].push_back(late_data[br][i]);
      @(posedge clk);
      #1;
      in_beat[br].valid = 1'b0;
    end
  endtask

  // Every written word out and the stream quiet afterwards
  task automatic wait_drained();
    while (pending_words() != 0) begin
      @(negedge clk);
    end
    repeat (6) begin
      @(negedge clk);
      compare_valid("out.valid", dut_out.valid, 1'b0);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests

  task automatic idle_after_reset();
    repeat (10) begin
      @(negedge clk);
      compare_valid("out.valid", dut_out.valid, 1'b0);
    end
  endtask

  task automatic parallel_frame();
    write_maps('1, CHANNEL_NUM_PIXEL);
    // Flag update, start, FIFO read and output register
    repeat (3) begin
      @(negedge clk);
      compare_valid("out.valid", dut_out.valid, 1'b0);
    end
    // All maps complete so the whole frame comes out without gaps
    repeat (BRANCH_NUM * CHANNEL_NUM_PIXEL) begin
      @(negedge clk);
      compare_valid("out.valid", dut_out.valid, 1'b1);
    end
    wait_drained();
  endtask

  task automatic partial_branch_one();
    write_maps('1, CHANNEL_NUM_PIXEL - 1);
    write_maps(5'b11110, 1);
    // Nothing may start while branch 1 is one word short
    repeat (30) begin
      @(negedge clk);
      compare_valid("out.valid", dut_out.valid, 1'b0);
    end
    write_maps(5'b00001, 1);
    wait_drained();
  endtask

  task automatic staggered_branches();
    for (int i = 0; i < CHANNEL_NUM_PIXEL; i++) begin
      gap_cycles[2][i] = {$random(seed)} % 5;
      late_data[2][i]  = $random(seed);
      gap_cycles[4][i] = {$random(seed)} % 5;
      late_data[4][i]  = $random(seed);
    end
    fork
      write_maps(5'b01011, CHANNEL_NUM_PIXEL);
      write_branch_gapped(2, 6);
      write_branch_gapped(4, 11);
    join
    wait_drained();
  endtask

  // Second frame only after the first is out
  task automatic back_to_back_frames();
    write_maps('1, CHANNEL_NUM_PIXEL);
    wait_drained();
    write_maps('1, CHANNEL_NUM_PIXEL);
    wait_drained();
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog

  initial begin
    seed       = 32'hfeb7;
    mon_branch = 0;
    mon_word   = 0;
    for (int b = 0; b < BRANCH_NUM; b++) begin
      in_beat[b] = '0;
    end
    wait (reset === 1'b0);
    idle_after_reset();
    parallel_frame();
    partial_branch_one();
    staggered_branches();
    back_to_back_frames();
    if (pending_words() != 0 || mon_branch != 0 || mon_word != 0) begin
      stop_with_failure("expected words were left over at the end of the run");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("timeout, the output stream did not finish in time");
  end

endmodule

`default_nettype wire

/* files.f */
source/cnn_data_pkg.sv
source/concat_cfg_pkg.sv
source/channel_fifo.sv
source/concat_drain_ctrl.sv
source/cnn_concat_5in.sv
test/clock_gen.sv
test/cnn_concat_5in_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the concat stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module cnn_concat_5in_tb \
  -f files.f \
  -o cnn_concat_5in_sim

# A fatal stop gives a nonzero exit, the search below decides
result=$(./obj_dir/cnn_concat_5in_sim 2>&1) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi
